/* src/wb_bus_pkg.sv */
// wishbone side definitions: bus widths, vector types and the
// master output struct
`default_nettype none

package wb_bus_pkg;

    // ==============================
    // bus widths
    // ==============================

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // one byte enable per byte lane of the data word
    localparam int SEL_W  = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // ==============================
    // master outputs
    // ==============================

    // everything the master drives onto the classic wishbone bus
    typedef struct packed {
        addr_t adr;
        data_t dat;
        sel_t  sel;
        logic  we;
        logic  cyc;
        logic  stb;
    } wb_out_t;

endpackage

`default_nettype wire

/* src/wb_req_pkg.sv */
// request side definitions: requester enum, selected request struct
// and the bus cycle states
`default_nettype none

package wb_req_pkg;

    import wb_bus_pkg::*;

    // ==============================
    // requesters
    // ==============================

    // which port the bus cycle in flight belongs to
    typedef enum logic [1:0] {
        SRC_NONE  = 2'd0,
        SRC_FETCH = 2'd1,
        SRC_DATA  = 2'd2
    } req_src_e;

    // one request as chosen by the arbiter, ready to be put on the bus
    typedef struct packed {
        addr_t    addr;
        data_t    data;
        sel_t     sel;
        // high for a data write
        logic     we;
        // high for a four word wrapping line fill
        logic     line;
        req_src_e src;
    } wb_req_t;

    // ==============================
    // bus cycle states
    // ==============================

    // beat waits for the non-final acks of a line fill,
    // last waits for the final ack of any transfer
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BEAT = 2'd1,
        ST_LAST = 2'd2
    } wb_state_e;

endpackage

`default_nettype wire

/* src/wb_req_arbiter.sv */
// request arbiter: tracks the port in service, picks data over fetch
// and builds the bus request
`timescale 1ns/1ps
`default_nettype none

module wb_req_arbiter
    import wb_bus_pkg::*, wb_req_pkg::*;
(
    input  wire logic    i_clk,
    input  wire logic    quick_n_reset,

    input  wire logic    i_if_req,
    input  wire logic    i_if_line,
    input  wire addr_t   i_if_addr,

    input  wire logic    i_dp_req,
    input  wire logic    i_dp_line,
    input  wire logic    i_dp_we,
    input  wire addr_t   i_dp_addr,
    input  wire data_t   i_dp_wdata,
    input  wire sel_t    i_dp_sel,

    input  wire logic    i_busy,
    input  wire logic    i_done,

    output logic         o_start,
    output wb_req_t      o_req
);

    // port whose transfer is on the bus right now
    req_src_e served_q;
    // port that just finished and still holds its req high
    req_src_e retire_q;

    logic if_free;
    logic dp_free;
    sel_t dp_sel;

    // byte lane pattern to the low address bits of the access
    function automatic logic [1:0] sel_to_lsb(input sel_t sel);
        logic [1:0] lsb;
        case (sel)
            4'b0001: lsb = 2'd0;
            4'b0010: lsb = 2'd1;
            4'b0100: lsb = 2'd2;
            4'b1000: lsb = 2'd3;
            4'b0011: lsb = 2'd0;
            4'b1100: lsb = 2'd2;
            default: lsb = 2'd0;
        endcase
        return lsb;
    endfunction

    // ==============================
    // request selection
    // ==============================

    // a port may not be picked again while it is served, nor before it
    // has dropped req after its last ready
    assign if_free = i_if_req && (served_q != SRC_FETCH) && (retire_q != SRC_FETCH);
    assign dp_free = i_dp_req && (served_q != SRC_DATA) && (retire_q != SRC_DATA);

    // reads always take all byte lanes
    assign dp_sel = i_dp_we ? i_dp_sel : '1;

    assign o_start = !i_busy && (dp_free || if_free);

    always_comb
    begin
        // the data port wins whenever both are free
        if (dp_free)
        begin
            o_req.addr = {i_dp_addr[ADDR_W-1:2], sel_to_lsb(dp_sel)};
            o_req.data = i_dp_wdata;
            o_req.sel  = dp_sel;
            o_req.we   = i_dp_we;
            // line fills are reads only
            o_req.line = i_dp_line && !i_dp_we;
            o_req.src  = SRC_DATA;
        end
        else
        begin
            // fetches are always word aligned reads
            o_req.addr = {i_if_addr[ADDR_W-1:2], 2'b00};
            o_req.data = '0;
            o_req.sel  = '1;
            o_req.we   = 1'b0;
            o_req.line = i_if_line;
            o_req.src  = SRC_FETCH;
        end
    end

    // ==============================
    // service tracking
    // ==============================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            served_q <= SRC_NONE;
            retire_q <= SRC_NONE;
        end
        else
        begin
            if (o_start)
                served_q <= o_req.src;
            else if (i_done)
                served_q <= SRC_NONE;

            // the finished port is held off until its req goes low
            if (i_done)
                retire_q <= served_q;
            else if ((retire_q == SRC_FETCH && !i_if_req) ||
                     (retire_q == SRC_DATA && !i_dp_req))
                retire_q <= SRC_NONE;
        end
    end

    a_no_start_busy: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_busy |-> !o_start);

    // the bus cycle state machine only finishes transfers this block started
    a_done_served: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        i_done |-> served_q != SRC_NONE);

endmodule

`default_nettype wire

/* src/wb_cycle_fsm.sv */
// bus cycle state machine: drives cyc, stb and the payload, counts line
// fill beats and wraps the burst address
`timescale 1ns/1ps
`default_nettype none

module wb_cycle_fsm
    import wb_bus_pkg::*, wb_req_pkg::*;
#(
    parameter int BURST_LEN = 4
)
(
    input  wire logic    i_clk,
    input  wire logic    quick_n_reset,

    input  wire logic    i_start,
    input  wire wb_req_t i_req,

    input  wire logic    i_wb_ack,

    output wb_out_t      o_wb,
    output logic         o_busy,
    output req_src_e     o_src,
    output logic         o_done
);

    // address bits above the byte offset that step through a line
    localparam int WRAP_W = $clog2(BURST_LEN);
    localparam int WRAP_HI = WRAP_W + 1;
    // beat count at which the next ack moves on to the final beat
    localparam logic [WRAP_W-1:0] LAST_BEAT = WRAP_W'(BURST_LEN - 2);

    wb_state_e         state_q;
    req_src_e          src_q;
    wb_out_t           wb_q;
    logic [WRAP_W-1:0] beat_q;

    assign o_wb   = wb_q;
    assign o_src  = src_q;
    assign o_busy = (state_q != ST_IDLE);
    // the final ack of a transfer, single word or line
    assign o_done = (state_q == ST_LAST) && i_wb_ack;

    // ==============================
    // state machine
    // ==============================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            state_q  <= ST_IDLE;
            src_q    <= SRC_NONE;
            beat_q   <= '0;
            wb_q.we  <= 1'b0;
            wb_q.cyc <= 1'b0;
            wb_q.stb <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    if (i_start)
                    begin
                        wb_q.adr <= i_req.addr;
                        wb_q.dat <= i_req.data;
                        wb_q.sel <= i_req.sel;
                        wb_q.we  <= i_req.we;
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        src_q    <= i_req.src;
                        beat_q   <= '0;
                        // a single word goes straight to its final beat
                        state_q  <= i_req.line ? ST_BEAT : ST_LAST;
                    end
                end

                ST_BEAT:
                begin
                    if (i_wb_ack)
                    begin
                        // next word of the line, wrapping inside the line
                        wb_q.adr[WRAP_HI:2] <= wb_q.adr[WRAP_HI:2] + WRAP_W'(1);
                        beat_q <= beat_q + WRAP_W'(1);
                        if (beat_q == LAST_BEAT)
                            state_q <= ST_LAST;
                    end
                end

                ST_LAST:
                begin
                    // cyc drops with stb, no bus ownership is kept
                    if (i_wb_ack)
                    begin
                        wb_q.we  <= 1'b0;
                        wb_q.cyc <= 1'b0;
                        wb_q.stb <= 1'b0;
                        src_q    <= SRC_NONE;
                        state_q  <= ST_IDLE;
                    end
                end

                default:
                begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // ==============================
    // bus checks
    // ==============================

    a_stb_cyc: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        wb_q.stb |-> wb_q.cyc);

    // a stalled slave sees the same request until it acks
    a_hold_stall: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (wb_q.stb && !i_wb_ack) |=> $stable(wb_q));

    a_beat_bound: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (state_q == ST_BEAT) |-> (beat_q <= LAST_BEAT));

endmodule

`default_nettype wire

/* src/wb_resp_router.sv */
// response router: turns bus acks into ready pulses for the port
// being served and hands back the read data
`timescale 1ns/1ps
`default_nettype none

module wb_resp_router
    import wb_bus_pkg::*, wb_req_pkg::*;
(
    input  wire req_src_e i_src,
    input  wire logic     i_we,
    input  wire logic     i_wb_ack,
    input  wire data_t    i_wb_dat,

    output logic          o_if_ready,
    output logic          o_dp_ready,
    output data_t         o_if_data,
    output data_t         o_dp_data
);

    logic read_ack;

    // the fetch port only ever reads, so a write ack is never its own
    assign read_ack = i_wb_ack && !i_we;

    assign o_if_ready = (i_src == SRC_FETCH) && read_ack;
    // data port readies cover writes as well as reads
    assign o_dp_ready = (i_src == SRC_DATA) && i_wb_ack;

    // read data is valid in the same cycle as the ready pulse
    assign o_if_data = i_wb_dat;
    assign o_dp_data = i_wb_dat;

    always_comb
    begin
        a_one_ready: assert (!(o_if_ready && o_dp_ready));
    end

endmodule

`default_nettype wire

/* src/wb_master.sv */
// wishbone bus master top: arbiter, bus cycle state machine and
// response router
`timescale 1ns/1ps
`default_nettype none

module wb_master
    import wb_bus_pkg::*, wb_req_pkg::*;
#(
    // beats per line fill
    parameter int BURST_LEN = 4
)
(
    input  wire logic  i_clk,
    input  wire logic  quick_n_reset,

    // instruction fetch port
    input  wire logic  i_if_req,
    input  wire logic  i_if_line,
    input  wire addr_t i_if_addr,
    output data_t      o_if_data,
    output logic       o_if_ready,

    // data port
    input  wire logic  i_dp_req,
    input  wire logic  i_dp_line,
    input  wire logic  i_dp_we,
    input  wire addr_t i_dp_addr,
    input  wire data_t i_dp_wdata,
    input  wire sel_t  i_dp_sel,
    output data_t      o_dp_data,
    output logic       o_dp_ready,

    // wishbone bus
    output wb_out_t    o_wb,
    input  wire data_t i_wb_dat,
    input  wire logic  i_wb_ack
);

    logic     start;
    wb_req_t  req;
    logic     busy;
    logic     done;
    req_src_e src;

    // ==============================
    // decode, execute, result
    // ==============================

    wb_req_arbiter u_arbiter (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_if_req      (i_if_req),
        .i_if_line     (i_if_line),
        .i_if_addr     (i_if_addr),
        .i_dp_req      (i_dp_req),
        .i_dp_line     (i_dp_line),
        .i_dp_we       (i_dp_we),
        .i_dp_addr     (i_dp_addr),
        .i_dp_wdata    (i_dp_wdata),
        .i_dp_sel      (i_dp_sel),
        .i_busy        (busy),
        .i_done        (done),
        .o_start       (start),
        .o_req         (req)
    );

    wb_cycle_fsm #(
        .BURST_LEN (BURST_LEN)
    ) u_cycle_fsm (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_start       (start),
        .i_req         (req),
        .i_wb_ack      (i_wb_ack),
        .o_wb          (o_wb),
        .o_busy        (busy),
        .o_src         (src),
        .o_done        (done)
    );

    // the write flag on the bus tells the router which acks are reads
    wb_resp_router u_resp_router (
        .i_src      (src),
        .i_we       (o_wb.we),
        .i_wb_ack   (i_wb_ack),
        .i_wb_dat   (i_wb_dat),
        .o_if_ready (o_if_ready),
        .o_dp_ready (o_dp_ready),
        .o_if_data  (o_if_data),
        .o_dp_data  (o_dp_data)
    );

endmodule

`default_nettype wire

/* bench/wb_mem_model.sv */
// word memory slave for the testbench with per beat wait states,
// combinational ack and read data
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model
    import wb_bus_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       quick_n_reset,
    input  wire wb_out_t    i_wb,
    // wait states for the next beat, sampled when a beat begins
    input  wire logic [1:0] i_delay,
    output data_t           o_dat,
    output logic            o_ack
);

    // 1 KiB of words, addressed by bits 9:2
    data_t      mem [0:255];
    logic [1:0] wait_q;
    logic [1:0] delay_q;
    logic       active;

    assign active = i_wb.cyc && i_wb.stb;
    // ack once the chosen number of wait states has passed
    assign o_ack  = active && (wait_q == delay_q);
    assign o_dat  = mem[i_wb.adr[9:2]];

    // ==============================
    // wait state counter
    // ==============================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            wait_q  <= 2'd0;
            delay_q <= 2'd0;
        end
        else if (!active || o_ack)
        begin
            // a new beat starts with a fresh delay
            wait_q  <= 2'd0;
            delay_q <= i_delay;
        end
        else
        begin
            wait_q <= wait_q + 2'd1;
        end
    end

    // ==============================
    // storage
    // ==============================

    always_ff @(posedge i_clk)
    begin
        if (!quick_n_reset)
        begin
            // every word is loaded with its own word address during reset
            for (int i = 0; i < 256; i++)
                mem[i] <= data_t'(i);
        end
        else if (o_ack && i_wb.we)
        begin
            for (int b = 0; b < SEL_W; b++)
                if (i_wb.sel[b])
                    mem[i_wb.adr[9:2]][8*b +: 8] <= i_wb.dat[8*b +: 8];
        end
    end

endmodule

`default_nettype wire

/* bench/wb_master_tb.sv */
// testbench for the wishbone bus master: clock, reset, request tasks,
// random wait states and the checking assertions
`timescale 1ns/1ps
`default_nettype none

module wb_master_tb
    import wb_bus_pkg::*;
();

    // cycles any single wait may take before it counts as hung
    localparam int TIMEOUT = 200;

    logic    i_clk;
    logic    quick_n_reset;
    logic    i_if_req;
    logic    i_if_line;
    addr_t   i_if_addr;
    data_t   o_if_data;
    logic    o_if_ready;
    logic    i_dp_req;
    logic    i_dp_line;
    logic    i_dp_we;
    addr_t   i_dp_addr;
    data_t   i_dp_wdata;
    sel_t    i_dp_sel;
    data_t   o_dp_data;
    logic    o_dp_ready;
    wb_out_t o_wb;
    data_t   i_wb_dat;
    logic    i_wb_ack;

    string      test_name = "reset";
    logic       started = 1'b0;
    logic       race_on = 1'b0;
    logic       exp_we = 1'b0;
    logic [1:0] exp_lsb = 2'd0;
    int         if_idx = 0;
    int         dp_idx = 0;
    // word addresses each port should see, in wrap order
    addr_t      exp_if_adr [0:3];
    addr_t      exp_dp_adr [0:3];
    // expected memory contents, kept from the preload rule and the writes
    data_t      shadow [0:255];
    addr_t      exp_if_cur;
    addr_t      exp_dp_cur;
    data_t      exp_if_dat;
    data_t      exp_dp_dat;
    logic [68:0] payload;
    logic [7:0] lfsr_q = 8'd12;
    logic [1:0] mem_delay = 2'd0;

    // one step of an 8 bit fibonacci lfsr with taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // low address bits that a byte enable pattern selects
    function automatic logic [1:0] byte_offset(input sel_t sel);
        logic [1:0] off;
        off = 2'd0;
        if (sel == 4'b0010)
            off = 2'd1;
        else if (sel == 4'b0100 || sel == 4'b1100)
            off = 2'd2;
        else if (sel == 4'b1000)
            off = 2'd3;
        return off;
    endfunction

    function automatic void stop_on_error(input string what);
        $display("%s", what);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endfunction

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // two fresh lfsr bits per cycle give the next ack delay of 0 to 3
    always @(posedge i_clk)
    begin
        logic [7:0] s;
        logic [1:0] d;
        s = lfsr_q;
        d[0] = s[0];
        s = lfsr_next(s);
        d[1] = s[0];
        s = lfsr_next(s);
        lfsr_q <= s;
        mem_delay <= d;
    end

    wb_master #(
        .BURST_LEN (4)
    ) wb_master_i (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_if_req      (i_if_req),
        .i_if_line     (i_if_line),
        .i_if_addr     (i_if_addr),
        .o_if_data     (o_if_data),
        .o_if_ready    (o_if_ready),
        .i_dp_req      (i_dp_req),
        .i_dp_line     (i_dp_line),
        .i_dp_we       (i_dp_we),
        .i_dp_addr     (i_dp_addr),
        .i_dp_wdata    (i_dp_wdata),
        .i_dp_sel      (i_dp_sel),
        .o_dp_data     (o_dp_data),
        .o_dp_ready    (o_dp_ready),
        .o_wb          (o_wb),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack)
    );

    wb_mem_model u_mem (
        .i_clk         (i_clk),
        .quick_n_reset (quick_n_reset),
        .i_wb          (o_wb),
        .i_delay       (mem_delay),
        .o_dat         (i_wb_dat),
        .o_ack         (i_wb_ack)
    );

    // the address and word each port should receive on its next ready
    always_comb
    begin
        exp_if_cur = exp_if_adr[if_idx[1:0]];
        exp_dp_cur = exp_dp_adr[dp_idx[1:0]];
        exp_if_dat = shadow[exp_if_cur[9:2]];
        exp_dp_dat = shadow[exp_dp_cur[9:2]];
    end

    assign payload = {o_wb.adr, o_wb.sel, o_wb.we, o_wb.dat};

    // ==============================
    // checks
    // ==============================

    a_idle_after_reset: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        !started |-> !o_wb.cyc && !o_wb.stb && !o_if_ready && !o_dp_ready)
        else stop_on_error($sformatf("error %s expected 0000 actual %b%b%b%b", test_name,
            $sampled(o_wb.cyc), $sampled(o_wb.stb), $sampled(o_if_ready),
            $sampled(o_dp_ready)));

    a_if_data: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_if_ready |-> o_if_data == exp_if_dat)
        else stop_on_error($sformatf("error %s expected %h actual %h", test_name,
            $sampled(exp_if_dat), $sampled(o_if_data)));

    // write acks carry no read data
    a_dp_data: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_dp_ready && !o_wb.we) |-> o_dp_data == exp_dp_dat)
        else stop_on_error($sformatf("error %s expected %h actual %h", test_name,
            $sampled(exp_dp_dat), $sampled(o_dp_data)));

    // every acked beat sits at the next word of the wrap order
    a_if_adr: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_if_ready |-> o_wb.adr == exp_if_cur)
        else stop_on_error($sformatf("error %s expected %h actual %h", test_name,
            $sampled(exp_if_cur), $sampled(o_wb.adr)));

    a_dp_adr: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_dp_ready |-> o_wb.adr[31:2] == exp_dp_cur[31:2])
        else stop_on_error($sformatf("error %s expected %h actual %h", test_name,
            $sampled(exp_dp_cur[31:2]), $sampled(o_wb.adr[31:2])));

    // reads take every byte lane from a word aligned address
    a_rd_lanes: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb.stb && !o_wb.we) |-> o_wb.sel == 4'hf && o_wb.adr[1:0] == 2'd0)
        else stop_on_error($sformatf("error %s expected f 0 actual %h %0d", test_name,
            $sampled(o_wb.sel), $sampled(o_wb.adr[1:0])));

    // a ready after the requester dropped req is one too many
    a_if_ready_req: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_if_ready |-> i_if_req)
        else stop_on_error($sformatf("fetch ready came with no fetch request in %s",
            test_name));

    a_dp_ready_req: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_dp_ready |-> i_dp_req)
        else stop_on_error($sformatf("data ready came with no data request in %s",
            test_name));

    // within one transfer only the word bits inside the line may move
    a_line_adr: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb.stb && $past(o_wb.stb)) |-> o_wb.adr[31:4] == $past(o_wb.adr[31:4]))
        else stop_on_error($sformatf("error %s expected %h actual %h", test_name,
            $past(o_wb.adr[31:4]), $sampled(o_wb.adr[31:4])));

    a_we: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        o_wb.stb |-> o_wb.we == exp_we)
        else stop_on_error($sformatf("error %s expected %b actual %b", test_name,
            $sampled(exp_we), $sampled(o_wb.we)));

    a_wr_lsb: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb.stb && o_wb.we) |-> o_wb.adr[1:0] == exp_lsb)
        else stop_on_error($sformatf("error %s expected %0d actual %0d", test_name,
            $sampled(exp_lsb), $sampled(o_wb.adr[1:0])));

    a_dp_first: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_if_ready && race_on) |-> dp_idx != 0)
        else stop_on_error($sformatf("fetch ready came before the data ready in %s",
            test_name));

    a_stall_hold: assert property (@(posedge i_clk) disable iff (!quick_n_reset)
        (o_wb.stb && !i_wb_ack) |=> $stable(payload))
        else stop_on_error($sformatf("error %s expected %h actual %h", test_name,
            $past(payload), $sampled(payload)));

    // ==============================
    // requesters
    // ==============================

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge i_clk);
    endtask

    // holds a fetch request until all its readies have arrived
    task automatic fetch_access(input logic line, input addr_t addr, input int beats);
        int         got;
        int         n;
        logic [1:0] word;
        got = 0;
        for (int k = 0; k < beats; k++)
        begin
            word = addr[3:2] + 2'(k);
            exp_if_adr[k] <= {addr[31:4], word, 2'b00};
        end
        if_idx <= 0;
        started <= 1'b1;
        i_if_req <= 1'b1;
        i_if_line <= line;
        i_if_addr <= addr;
        for (n = 0; n < TIMEOUT && got < beats; n++)
        begin
            @(posedge i_clk);
            if (o_if_ready)
            begin
                got++;
                if_idx <= if_idx + 1;
            end
        end
        i_if_req <= 1'b0;
        if (got < beats)
            stop_on_error($sformatf("fetch readies did not arrive in time in %s", test_name));
    endtask

    task automatic data_access(input logic we, input logic line, input addr_t addr,
                               input data_t wdata, input sel_t sel, input int beats);
        int         got;
        int         n;
        logic [1:0] word;
        got = 0;
        for (int k = 0; k < beats; k++)
        begin
            word = addr[3:2] + 2'(k);
            exp_dp_adr[k] <= {addr[31:4], word, 2'b00};
        end
        dp_idx <= 0;
        exp_we <= we;
        exp_lsb <= byte_offset(sel);
        started <= 1'b1;
        i_dp_req <= 1'b1;
        i_dp_line <= line;
        i_dp_we <= we;
        i_dp_addr <= addr;
        i_dp_wdata <= wdata;
        i_dp_sel <= sel;
        for (n = 0; n < TIMEOUT && got < beats; n++)
        begin
            @(posedge i_clk);
            if (o_dp_ready)
            begin
                got++;
                dp_idx <= dp_idx + 1;
            end
        end
        i_dp_req <= 1'b0;
        exp_we <= 1'b0;
        // a completed write lands in the expected memory lane by lane
        if (we)
            for (int b = 0; b < SEL_W; b++)
                if (sel[b])
                    shadow[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
        if (got < beats)
            stop_on_error($sformatf("data readies did not arrive in time in %s", test_name));
    endtask

    // ==============================
    // stimulus
    // ==============================

    initial
    begin
        for (int i = 0; i < 256; i++)
            shadow[i] = data_t'(i);
        quick_n_reset = 1'b0;
        i_if_req = 1'b0;
        i_if_line = 1'b0;
        i_if_addr = '0;
        i_dp_req = 1'b0;
        i_dp_line = 1'b0;
        i_dp_we = 1'b0;
        i_dp_addr = '0;
        i_dp_wdata = '0;
        i_dp_sel = '0;
        repeat (3) @(posedge i_clk);
        quick_n_reset <= 1'b1;
        idle_cycles(4);

        // an unaligned fetch address still reads the word at 0x48
        test_name = "fetch_single";
        fetch_access(1'b0, 32'h0000_004a, 1);
        idle_cycles(4);

        // word 2 of the line at 0x80, so the words come as 2 3 0 1
        test_name = "fetch_line";
        fetch_access(1'b1, 32'h0000_0088, 4);
        idle_cycles(2);

        test_name = "data_write";
        data_access(1'b1, 1'b0, 32'h0000_0104, 32'ha5c3_7e19, 4'b1100, 1);
        idle_cycles(2);

        test_name = "data_line";
        data_access(1'b0, 1'b1, 32'h0000_010c, '0, 4'hf, 4);
        idle_cycles(2);

        // both ports raise req on the same edge
        test_name = "priority";
        race_on <= 1'b1;
        fork
            fetch_access(1'b1, 32'h0000_0200, 4);
            data_access(1'b0, 1'b0, 32'h0000_0310, '0, 4'hf, 1);
        join
        race_on <= 1'b0;
        idle_cycles(2);

        test_name = "wait_states";
        for (int k = 0; k < 6; k++)
        begin
            fetch_access(1'b1, addr_t'(32'h0000_0240 + 20 * k), 4);
            idle_cycles(2);
            data_access(1'b0, 1'b1, addr_t'(32'h0000_0380 + 12 * k), '0, 4'hf, 4);
            idle_cycles(2);
        end

        idle_cycles(4);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/wb_bus_pkg.sv
src/wb_req_pkg.sv
src/wb_req_arbiter.sv
src/wb_cycle_fsm.sv
src/wb_resp_router.sv
src/wb_master.sv
bench/wb_mem_model.sv
bench/wb_master_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the wb_master testbench with verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module wb_master_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vwb_master_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q '\*\*\* FAILED \*\*\*' "$LOG"; then
    echo "simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
echo "simulation passed"
exit 0
